// File: verilog.f
hw/dcache_geom_pkg.sv
hw/dcache_ctrl_pkg.sv
hw/dcache_main_ctrl.sv
hw/dcache_way_store.sv
hw/dcache_hit_write_buffer.sv
hw/dcache_victim_select.sv
hw/dcache_top.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

// File: tb/dcache_tb.sv
module dcache_tb
    import dcache_geom_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period    = 4;
    localparam int reset_cycles  = 5;
    localparam int directed_ops  = 20;
    localparam int random_ops    = 400;
    localparam int cycles_per_op = 200;

    typedef struct packed {
        logic  is_load;
        word_t word;
    } expect_t;

    logic    clk;
    logic    reset;
    logic    valid;
    logic    op;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    logic    ret_last;
    word_t   ret_data;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    // byte image of memory as the CPU should see it
    logic [7:0] shadow [addr_t];
    expect_t    pending [$];
    int         rd_count;
    int         wb_count;
    addr_t      last_rd_addr;
    addr_t      last_wr_addr;

    tag_t   rand_tags [6] = '{20'h00001, 20'h0a0a0, 20'h7e001, 20'h3c3c3, 20'hfffff, 20'h54321};
    index_t rand_sets [4] = '{8'h40, 8'h41, 8'h80, 8'hc3};

    dcache_top i_dut (.*);

    dcache_mem_model i_mem (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // memory content before any write-back, same rule as the memory model
    function automatic word_t initial_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h3c5a_0f69;
    endfunction

    function automatic word_t expected_word(addr_t a);
        addr_t base;
        word_t w;
        base = {a[31:2], 2'b00};
        w    = initial_word(base);
        for (int k = 0; k < 4; k++) begin
            if (shadow.exists(base + addr_t'(k))) begin
                w[k*8 +: 8] = shadow[base + addr_t'(k)];
            end
        end
        return w;
    endfunction

    function automatic line_t expected_line(addr_t a);
        line_t l;
        for (int b = 0; b < words_per_line; b++) begin
            l[b*32 +: 32] = expected_word(a + addr_t'(4 * b));
        end
        return l;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // holds the request until addr_ok, then records what its response must be
    task automatic send_request(input logic st, input addr_t a, input strb_t be,
                                input word_t d);
        expect_t e;
        valid  = 1'b1;
        op     = st;
        tag    = a[31:12];
        index  = a[11:4];
        offset = a[3:0];
        wstrb  = be;
        wdata  = d;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        e.is_load = !st;
        e.word    = expected_word(a);
        pending.push_back(e);
        if (st) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    shadow[{a[31:2], 2'b00} + addr_t'(k)] = d[k*8 +: 8];
                end
            end
        end
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_responses();
        while (pending.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // responses come back in request order
    always @(posedge clk) begin
        expect_t e;
        if (!reset && data_ok) begin
            if (pending.size() == 0) begin
                abort_run("data_ok pulsed with no request outstanding");
            end else begin
                e = pending.pop_front();
                if (e.is_load) begin
                    check_value("rdata", rdata, e.word);
                end
            end
        end
    end

    // memory bus monitor, every evicted line must match the shadow
    always @(posedge clk) begin
        if (!reset && rd_req && rd_rdy) begin
            rd_count++;
            last_rd_addr = rd_addr;
        end
        if (!reset && wr_req) begin
            wb_count++;
            last_wr_addr = wr_addr;
            check_value("wr_data", wr_data, expected_line(wr_addr));
        end
    end

    initial begin
        #((directed_ops + random_ops) * cycles_per_op * clk_period +
          (reset_cycles + num_sets + 50) * clk_period);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        addr_t     a;
        bank_sel_t b;
        int        rd_before;
        int        wb_before;
        void'($urandom(75));
        reset      = 1'b1;
        valid      = 1'b0;
        op         = 1'b0;
        index      = '0;
        tag        = '0;
        offset     = '0;
        wstrb      = '0;
        wdata      = '0;
        rd_count   = 0;
        wb_count   = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        // valid sweep keeps addr_ok low for a while
        while (!addr_ok) begin
            @(posedge clk);
            #1;
        end

        $display("cold load");
        rd_before = rd_count;
        send_request(1'b0, 32'h1234_5108, 4'h0, 32'h0);
        wait_responses();
        check_value("read count", rd_count, rd_before + 1);
        check_value("rd_addr", last_rd_addr, 32'h1234_5100);

        $display("load hit in the same line");
        rd_before = rd_count;
        send_request(1'b0, 32'h1234_5104, 4'h0, 32'h0);
        wait_responses();

        $display("back-to-back store and load hits");
        send_request(1'b1, 32'h1234_5104, 4'b0110, 32'ha1b2_c3d4);
        send_request(1'b0, 32'h1234_5104, 4'h0, 32'h0);
        send_request(1'b1, 32'h1234_510c, 4'b1001, 32'h0102_0304);
        send_request(1'b0, 32'h1234_5100, 4'h0, 32'h0);
        send_request(1'b0, 32'h1234_510c, 4'h0, 32'h0);
        wait_responses();
        check_value("read count", rd_count, rd_before);

        $display("store miss allocates");
        rd_before = rd_count;
        send_request(1'b1, 32'h5555_521c, 4'b1100, 32'hdead_beef);
        send_request(1'b0, 32'h5555_521c, 4'h0, 32'h0);
        wait_responses();
        check_value("read count", rd_count, rd_before + 1);

        $display("dirty eviction");
        send_request(1'b1, 32'haaaa_1304, 4'b1111, 32'h1111_2222);
        send_request(1'b1, 32'hbbbb_2304, 4'b0011, 32'h3333_4444);
        wait_responses();
        wb_before = wb_count;
        send_request(1'b1, 32'hcccc_3304, 4'b1100, 32'h5555_6666);
        // hits once the eviction and refill are over
        send_request(1'b0, 32'hcccc_3304, 4'h0, 32'h0);
        wait_responses();
        check_value("write-back count", wb_count, wb_before + 1);
        if (last_wr_addr != 32'haaaa_1300 && last_wr_addr != 32'hbbbb_2300) begin
            abort_run("write-back address is neither older line of the set");
        end
        send_request(1'b0, 32'haaaa_1304, 4'h0, 32'h0);
        send_request(1'b0, 32'hbbbb_2304, 4'h0, 32'h0);
        wait_responses();

        $display("random loads and stores");
        for (int n = 0; n < random_ops; n++) begin
            b = $urandom_range(0, 3);
            a = {rand_tags[$urandom_range(0, 5)], rand_sets[$urandom_range(0, 3)], b, 2'b00};
            send_request($urandom_range(0, 1), a, strb_t'($urandom_range(0, 15)), $urandom);
        end
        wait_responses();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tb/dcache_mem_model.sv
module dcache_mem_model
    import dcache_geom_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  rd_rdy,
    output logic  ret_valid,
    output logic  ret_last,
    output word_t ret_data,
    input  logic  wr_req,
    input  addr_t wr_addr,
    input  line_t wr_data,
    output logic  wr_rdy
);

    timeunit 1ns;
    timeprecision 100ps;

    // sparse word storage, keyed by the byte address of the word
    word_t mem [addr_t];

    // untouched memory, every address bit feeds the pattern
    function automatic word_t backing_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h3c5a_0f69;
    endfunction

    function automatic word_t read_word(addr_t a);
        return mem.exists(a) ? mem[a] : backing_word(a);
    endfunction

    // line read with a random accept delay, then four beats with random gaps
    initial begin
        addr_t base;
        int    gap;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            if (!reset && rd_req && rd_rdy) begin
                base = rd_addr;
                #1;
                rd_rdy = 1'b0;
                for (int b = 0; b < words_per_line; b++) begin
                    gap = $urandom_range(0, 2);
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == words_per_line - 1);
                    ret_data  = read_word(base + addr_t'(4 * b));
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end else begin
                #1;
                rd_rdy = ($urandom_range(0, 2) == 0);
            end
        end
    end

    // write-back burst lands in the array on its single wr_req cycle
    initial begin
        wr_rdy = 1'b0;
        forever begin
            @(posedge clk);
            if (!reset && wr_req) begin
                for (int b = 0; b < words_per_line; b++) begin
                    mem[wr_addr + addr_t'(4 * b)] = wr_data[b*32 +: 32];
                end
            end
            #1;
            wr_rdy = ($urandom_range(0, 3) == 0);
        end
    end

endmodule

// File: hw/dcache_top.sv
module dcache_top
    import dcache_geom_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // cpu side
    input  logic    valid,
    input  logic    op,
    input  index_t  index,
    input  tag_t    tag,
    input  offset_t offset,
    input  strb_t   wstrb,
    input  word_t   wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    // memory side
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  logic    ret_last,
    input  word_t   ret_data,
    output logic    wr_req,
    output addr_t   wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy
);

    // request buffer and controller strobes
    index_t    array_index;
    index_t    req_index;
    tag_t      req_tag;
    offset_t   req_offset;
    strb_t     req_wstrb;
    word_t     req_wdata;
    logic      req_op;
    logic      in_lookup;
    logic      in_refill;
    logic      refill_beat;
    bank_sel_t refill_word;
    way_mask_t victim_way;
    logic      store_hit_take;

    // way store results
    way_mask_t way_hit;
    word_t     lookup_word;
    way_mask_t valid_ways;
    tag_t      victim_tag;
    logic      sweep_done;

    // replacement choice
    way_mask_t replace_way;
    logic      replace_dirty;

    // pending store hit
    logic      wb_full;
    index_t    wb_index;
    bank_sel_t wb_bank;
    way_mask_t wb_way;
    strb_t     wb_wstrb;
    word_t     wb_wdata;

    dcache_main_ctrl i_main_ctrl (.*);

    // victim line goes straight out as the write-back burst
    dcache_way_store i_way_store (
        .victim_line (wr_data),
        .*
    );

    dcache_hit_write_buffer i_hit_write_buffer (.*);

    dcache_victim_select i_victim_select (.*);

endmodule

// File: hw/dcache_victim_select.sv
module dcache_victim_select
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  index_t    array_index,
    input  way_mask_t valid_ways,
    input  way_mask_t way_hit,
    input  logic      in_refill,
    input  logic      ret_last,
    input  logic      ret_valid,
    input  way_mask_t victim_way,
    input  logic      req_op,
    input  logic      wb_full,
    input  index_t    wb_index,
    input  way_mask_t wb_way,
    output way_mask_t replace_way,
    output logic      replace_dirty
);

    logic [7:0] lfsr;
    way_mask_t  dirty_mem [num_sets];
    way_mask_t  dirty_q;
    way_mask_t  dirty_wdata;
    way_mask_t  set_dirty;
    index_t     dirty_waddr;
    logic       dirty_we;
    logic       refill_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= lfsr_seed;
        end else begin
            lfsr <= {lfsr[6], lfsr[5:3] ^ {3{lfsr[7]}}, lfsr[2:0], lfsr[7]};
        end
    end

    assign refill_done = in_refill && ret_valid && ret_last;

    // refill end takes the request type, a buffered store hit sets its way
    always_comb begin
        dirty_we = refill_done || wb_full;
        if (refill_done) begin
            dirty_waddr = array_index;
            dirty_wdata = (dirty_mem[array_index] & ~victim_way) |
                          (victim_way & {num_ways{req_op}});
        end else begin
            dirty_waddr = wb_index;
            dirty_wdata = dirty_mem[wb_index] | wb_way;
        end
    end

    // read follows the tag array timing, with same-cycle writes forwarded
    always_ff @(posedge clk) begin
        if (dirty_we) begin
            dirty_mem[dirty_waddr] <= dirty_wdata;
        end
        if (dirty_we && (dirty_waddr == array_index)) begin
            dirty_q <= dirty_wdata;
        end else begin
            dirty_q <= dirty_mem[array_index];
        end
    end

    // store hit still sitting in the buffer for this set
    assign set_dirty = dirty_q | ((wb_full && (wb_index == array_index)) ? wb_way : '0);

    always_comb begin
        if (!valid_ways[0]) begin
            replace_way = way_mask_t'(1);
        end else if (!valid_ways[1]) begin
            replace_way = way_mask_t'(2);
        end else begin
            replace_way = lfsr[6] ? way_mask_t'(2) : way_mask_t'(1);
        end
    end

    // only a valid line can need a write-back
    assign replace_dirty = !(|way_hit) && |(replace_way & set_dirty & valid_ways);

endmodule

// File: hw/dcache_hit_write_buffer.sv
module dcache_hit_write_buffer
    import dcache_geom_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      store_hit_take,
    input  index_t    req_index,
    input  offset_t   req_offset,
    input  strb_t     req_wstrb,
    input  word_t     req_wdata,
    input  way_mask_t way_hit,
    output logic      wb_full,
    output index_t    wb_index,
    output bank_sel_t wb_bank,
    output way_mask_t wb_way,
    output strb_t     wb_wstrb,
    output word_t     wb_wdata
);

    // full for exactly the cycle the bank is written,
    // or longer when store hits follow each other
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_full <= 1'b0;
        end else begin
            wb_full <= store_hit_take;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit_take) begin
            wb_index <= req_index;
            wb_bank  <= req_offset[3:2];
            wb_way   <= way_hit;
            wb_wstrb <= req_wstrb;
            wb_wdata <= req_wdata;
        end
    end

    // hit vector from the way store must name one way
    a_wb_way_onehot: assert property (
        @(posedge clk) disable iff (reset) wb_full |-> $onehot(wb_way)
    );

endmodule

// File: hw/dcache_way_store.sv
module dcache_way_store
    import dcache_geom_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  index_t    array_index,
    input  tag_t      req_tag,
    input  offset_t   req_offset,
    input  strb_t     req_wstrb,
    input  word_t     req_wdata,
    input  logic      req_op,
    input  logic      in_lookup,
    input  logic      in_refill,
    input  logic      refill_beat,
    input  bank_sel_t refill_word,
    input  way_mask_t victim_way,
    input  logic      ret_valid,
    input  logic      ret_last,
    input  word_t     ret_data,
    input  logic      wb_full,
    input  index_t    wb_index,
    input  bank_sel_t wb_bank,
    input  way_mask_t wb_way,
    input  strb_t     wb_wstrb,
    input  word_t     wb_wdata,
    output way_mask_t way_hit,
    output word_t     lookup_word,
    output way_mask_t valid_ways,
    output tag_t      victim_tag,
    output line_t     victim_line,
    output logic      sweep_done
);

    index_t sweep_cnt;
    logic   tag_fill;
    word_t  store_merge;
    word_t  fill_word;

    wire tag_t      way_tag  [num_ways];
    wire line_t     way_line [num_ways];
    wire way_mask_t way_valid;
    wire way_mask_t tag_match;

    // valid clear sweep, one set per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_cnt  <= '0;
            sweep_done <= 1'b0;
        end else if (!sweep_done) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == index_t'(num_sets - 1)) begin
                sweep_done <= 1'b1;
            end
        end
    end

    assign tag_fill = in_refill && ret_valid && ret_last;

    // store bytes over the returned word
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            store_merge[k*8 +: 8] = req_wstrb[k] ? req_wdata[k*8 +: 8] : ret_data[k*8 +: 8];
        end
    end

    assign fill_word = (refill_beat && req_op) ? store_merge : ret_data;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        logic [tag_width:0] tagv_mem [num_sets];
        logic [tag_width:0] tagv_q;
        logic               tag_we;
        index_t             tag_waddr;

        assign tag_we    = !sweep_done || (tag_fill && victim_way[w]);
        assign tag_waddr = sweep_done ? array_index : sweep_cnt;

        // outputs hold during refill so the victim stays stable
        always_ff @(posedge clk) begin
            if (tag_we) begin
                tagv_mem[tag_waddr] <= sweep_done ? {req_tag, 1'b1} : '0;
            end
            if (!in_refill) begin
                tagv_q <= tagv_mem[array_index];
            end
        end

        assign way_tag[w]   = tagv_q[tag_width:1];
        assign way_valid[w] = tagv_q[0];
        assign tag_match[w] = (tagv_q[tag_width:1] == req_tag);

        for (genvar b = 0; b < words_per_line; b++) begin : g_bank
            word_t  bank_mem [num_sets];
            word_t  bank_q;
            logic   wb_sel;
            logic   fill_sel;
            strb_t  bank_we;
            index_t bank_waddr;
            word_t  bank_wdata;

            // write buffer and refill never overlap
            assign wb_sel     = wb_full && wb_way[w] && (wb_bank == bank_sel_t'(b));
            assign fill_sel   = in_refill && ret_valid && victim_way[w] &&
                                (refill_word == bank_sel_t'(b));
            assign bank_we    = wb_sel ? wb_wstrb : {4{fill_sel}};
            assign bank_waddr = wb_sel ? wb_index : array_index;
            assign bank_wdata = wb_sel ? wb_wdata : fill_word;

            always_ff @(posedge clk) begin
                for (int k = 0; k < 4; k++) begin
                    if (bank_we[k]) begin
                        bank_mem[bank_waddr][k*8 +: 8] <= bank_wdata[k*8 +: 8];
                    end
                end
                if (!in_refill) begin
                    bank_q <= bank_mem[array_index];
                end
            end

            assign way_line[w][b*32 +: 32] = bank_q;
        end
    end

    assign valid_ways = way_valid;
    assign way_hit    = {num_ways{in_lookup}} & way_valid & tag_match;

    always_comb begin
        lookup_word = '0;
        victim_tag  = '0;
        victim_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_hit[w]) begin
                lookup_word |= way_line[w][req_offset[3:2]*32 +: 32];
            end
            if (victim_way[w]) begin
                victim_tag  |= way_tag[w];
                victim_line |= way_line[w];
            end
        end
    end

    // a refill only installs a tag that missed in every way
    a_hit_onehot0: assert property (
        @(posedge clk) disable iff (reset) $onehot0(way_hit)
    );

endmodule

// File: hw/dcache_main_ctrl.sv
module dcache_main_ctrl
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      valid,
    input  logic      op,
    input  index_t    index,
    input  tag_t      tag,
    input  offset_t   offset,
    input  strb_t     wstrb,
    input  word_t     wdata,
    input  way_mask_t way_hit,
    input  word_t     lookup_word,
    input  way_mask_t replace_way,
    input  logic      replace_dirty,
    input  tag_t      victim_tag,
    input  logic      wb_full,
    input  bank_sel_t wb_bank,
    input  logic      sweep_done,
    input  logic      rd_rdy,
    input  logic      wr_rdy,
    input  logic      ret_valid,
    input  logic      ret_last,
    input  word_t     ret_data,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     rdata,
    output logic      rd_req,
    output addr_t     rd_addr,
    output logic      wr_req,
    output addr_t     wr_addr,
    output index_t    array_index,
    output index_t    req_index,
    output tag_t      req_tag,
    output offset_t   req_offset,
    output strb_t     req_wstrb,
    output word_t     req_wdata,
    output logic      req_op,
    output logic      in_lookup,
    output logic      in_refill,
    output logic      refill_beat,
    output bank_sel_t refill_word,
    output way_mask_t victim_way,
    output logic      store_hit_take
);

    main_state_t state;
    logic        cache_hit;
    logic        wb_conflict;
    logic        st_ld_conflict;
    logic        accept;

    assign in_lookup = (state == lookup);
    assign in_refill = (state == refill);
    assign cache_hit = |way_hit;

    // bank hazards against the pending store hit and the store now in lookup
    assign wb_conflict    = wb_full && (wb_bank == offset[3:2]);
    assign st_ld_conflict = req_op && !op && (req_offset[3:2] == offset[3:2]);

    // a lookup only takes a new request when it hits
    assign addr_ok = ((state == idle) && sweep_done && !wb_conflict) ||
                     (in_lookup && cache_hit && !wb_conflict && !st_ld_conflict);
    assign accept  = valid && addr_ok;

    // arrays read the incoming set on acceptance, otherwise keep the buffered one
    assign array_index = addr_ok ? index : req_index;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= idle;
            wr_req      <= 1'b0;
            victim_way  <= '0;
            refill_word <= '0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (accept) begin
                        state <= lookup;
                    end else if (cache_hit) begin
                        state <= idle;
                    end else begin
                        victim_way <= replace_way;
                        state      <= replace_dirty ? miss : replace;
                    end
                end
                miss: begin
                    if (wr_rdy) begin
                        state  <= replace;
                        wr_req <= 1'b1;
                    end
                end
                replace: begin
                    wr_req <= 1'b0;
                    if (rd_req && rd_rdy) begin
                        state       <= refill;
                        refill_word <= '0;
                    end
                end
                refill: begin
                    if (ret_valid) begin
                        refill_word <= refill_word + 1'b1;
                        if (ret_last) begin
                            state <= idle;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // line read waits until the write-back pulse has gone out
    assign rd_req  = (state == replace) && !wr_req;
    assign rd_addr = {req_tag, req_index, offset_t'(0)};
    assign wr_addr = {victim_tag, req_index, offset_t'(0)};

    // the beat that carries the missed word
    assign refill_beat = in_refill && ret_valid && (refill_word == req_offset[3:2]);

    // stores complete in lookup, hit or miss
    assign data_ok = (in_lookup && (cache_hit || req_op)) || (refill_beat && !req_op);
    assign rdata   = in_refill ? ret_data : lookup_word;

    assign store_hit_take = in_lookup && cache_hit && req_op;

    // the fourth beat, and only that one, closes the line
    a_last_on_fourth_beat: assert property (
        @(posedge clk) disable iff (reset)
            ret_valid |-> (ret_last == (refill_word == bank_sel_t'(words_per_line - 1)))
    );

    // the memory only answers a line read that was issued
    a_ret_in_refill: assert property (
        @(posedge clk) disable iff (reset) ret_valid |-> in_refill
    );

endmodule

// File: hw/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    // main controller states
    // miss waits to write back the victim, replace waits to issue the line read
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } main_state_t;

    // replacement LFSR start value
    localparam logic [7:0] lfsr_seed = 8'd1;

endpackage

// File: hw/dcache_geom_pkg.sv
package dcache_geom_pkg;

    // cache geometry
    localparam int num_ways       = 2;
    localparam int num_sets       = 256;
    localparam int words_per_line = 4;

    // address split, tag | index | offset
    localparam int tag_width    = 20;
    localparam int index_width  = 8;
    localparam int offset_width = 4;

    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [index_width-1:0]  index_t;
    typedef logic [offset_width-1:0] offset_t;

    // word number inside a line, offset bits 3..2
    typedef logic [$clog2(words_per_line)-1:0] bank_sel_t;

    typedef logic [31:0]                    word_t;
    typedef logic [3:0]                     strb_t;
    typedef logic [words_per_line*32-1:0]   line_t;
    typedef logic [num_ways-1:0]            way_mask_t;

    typedef logic [tag_width+index_width+offset_width-1:0] addr_t;

endpackage
